/* video_input.txt */
# Hex fields: W addr data, T addr data, C addr data, R addr expected
# P x y rgb, I irq_level irqstat; several commands may share a line
R 0 00  R A 00  R C 00  R D 00  R E 00
# Line 0 matches the reset VIRQLINE
R F 01
W F 01  R F 00
W 0 81  R 0 81  W A 15  R A 15  W D 2A  R D 2A
W E 03  R E 03  W E 00  W 5 77  R 5 00
# Palette 0 = 123, 1 = F00, 2 = 0F0
W A 00  W B 23  W A 01  W B A1  R B 01
W A 02  W B 00  W A 03  W B 0F
W A 04  W B F0  W A 05  W B 00  W A 04  R B F0
# Glyphs 41 and 42 at row 2, cell row 1 column 2 on both pages
C 20A A0  C 212 0F
T 14 41  T 15 12  T 54 42  T 55 21
W 0 01  P 10 0A F00  P 11 0A 0F0  P 12 0A F00
W 0 81  P 10 0A F00  P 17 0A 0F0
P 46 05 000  P 10 24 000
W 0 00  P 00 00 123
# Line interrupt at line 5, then vblank
W F 03  W D 05  W E 01  I 1 01
W F 01  I 0 00
W E 02  I 1 02  W F 02  I 0 00
# Masked source still sets status
W E 00  P 10 0A 123  I 0 01

/* project.f */
video_pkg.sv
video_timing.sv
video_regs.sv
text_fetch.sv
palette.sv
video.sv
video_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f --top-module video_tb -o video_sim
./obj_dir/video_sim

/* video_tb.sv */
`timescale 1ns/10ps

module video_tb import video_pkg::*; ();

    localparam int H_TOTAL      = 80;
    localparam int H_SYNC_START = 68;
    localparam int H_SYNC_END   = 72;
    localparam int V_TOTAL      = 40;
    localparam int V_SYNC_START = 34;
    localparam int WAIT_LIMIT   = 5000;

    logic       vclk;
    logic       reset;
    io_req_t    io;
    ram_req_t   tram;
    ram_req_t   chram;
    logic [7:0] io_rddata;
    logic [7:0] tram_rddata;
    logic [7:0] chram_rddata;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;
    logic       vga_hsync;
    logic       vga_vsync;
    logic       irq;

    // Pixel now on the VGA outputs
    int h;
    int v;
    bit pos_valid;
    bit prev_hs;
    bit prev_vs;
    int cyc;
    int last_hrise = -1;
    int last_vrise = -1;
    bit vsync_checked;

    video dut0 (.*);    // Default 64x32 active screen

    initial begin
        vclk = 1'b0;
        forever #50 vclk = ~vclk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Error handling
    ////////////////////////////////////////////////////////////////////////////
    task automatic stop_with(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic wrong_value(string sig, int exp, int act);
        stop_with($sformatf("mismatch at %0t: %s expected %0h actual %0h", $time, sig, exp, act));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Cycle stepping and raster tracking
    ////////////////////////////////////////////////////////////////////////////
    task automatic tick();
        bit exp_hs;
        @(negedge vclk);
        cyc++;
        if (vga_hsync && !prev_hs) begin
            if (last_hrise >= 0)
                assert (cyc - last_hrise == H_TOTAL)
                else wrong_value("vga_hsync period", H_TOTAL, cyc - last_hrise);
            last_hrise = cyc;
        end
        if (vga_vsync && !prev_vs) begin
            if (last_vrise >= 0) begin
                assert (cyc - last_vrise == H_TOTAL * V_TOTAL)
                else wrong_value("vga_vsync period", H_TOTAL * V_TOTAL, cyc - last_vrise);
                vsync_checked = 1'b1;
            end
            last_vrise = cyc;
            h = 0;                      // First pixel of the sync line
            v = V_SYNC_START;
            pos_valid = 1'b1;
        end else if (pos_valid) begin
            h = (h == H_TOTAL - 1) ? 0 : h + 1;
            if (h == 0)
                v = (v == V_TOTAL - 1) ? 0 : v + 1;
        end
        exp_hs = (h >= H_SYNC_START) && (h < H_SYNC_END);
        if (pos_valid)
            assert (vga_hsync == exp_hs)
            else wrong_value("vga_hsync", int'(exp_hs), int'(vga_hsync));
        prev_hs = vga_hsync;
        prev_vs = vga_vsync;
    endtask

    // One bus cycle with inputs changed on the rising edge
    task automatic bus_cycle(io_req_t i, ram_req_t t, ram_req_t c);
        @(posedge vclk);
        io    <= i;
        tram  <= t;
        chram <= c;
        tick();
    endtask

    task automatic wait_pixel(int x, int y);
        int count;
        count = 0;
        // A few cycles first so the pipeline sees the latest writes
        while (!(pos_valid && h == x && v == y && count >= 6)) begin
            if (count == WAIT_LIMIT)
                stop_with($sformatf("pixel %0h,%0h never came on the outputs", x, y));
            tick();
            count++;
        end
    endtask

    task automatic wait_irq(bit level);
        int count;
        count = 0;
        while (irq !== level) begin
            if (count == WAIT_LIMIT)
                stop_with($sformatf("irq never went to %0d", level));
            tick();
            count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Command file
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int fd;
        int n;
        int a;
        int d;
        int e;
        logic [7:0] cmd;
        string line;
        reset = 1'b1;
        io    = '0;
        tram  = '0;
        chram = '0;
        fd = $fopen("video_input.txt", "r");
        if (fd == 0)
            stop_with("could not open video_input.txt");
        repeat (8) begin
            tick();
            assert (!vga_hsync && !vga_vsync && {vga_r, vga_g, vga_b} == 12'h000)
            else stop_with("VGA outputs were not idle during reset");
        end
        @(posedge vclk);
        reset <= 1'b0;
        tick();

        while ($fscanf(fd, " %c", cmd) == 1) begin
            case (cmd)
                "#": n = $fgets(line, fd);
                "W": begin
                    n = $fscanf(fd, "%h %h", a, d);
                    bus_cycle(io_req_t'{addr: a[3:0], wrdata: d[7:0], wren: 1'b1}, '0, '0);
                end
                "T": begin
                    n = $fscanf(fd, "%h %h", a, d);
                    bus_cycle('0, ram_req_t'{addr: a[10:0], wrdata: d[7:0], wren: 1'b1}, '0);
                    // Read the byte back, data follows the address by one cycle
                    bus_cycle('0, ram_req_t'{addr: a[10:0], wrdata: 8'h00, wren: 1'b0}, '0);
                    bus_cycle('0, '0, '0);
                    assert (tram_rddata == d[7:0])
                    else wrong_value($sformatf("tram_rddata[%0h]", a), d, int'(tram_rddata));
                end
                "C": begin
                    n = $fscanf(fd, "%h %h", a, d);
                    bus_cycle('0, '0, ram_req_t'{addr: a[10:0], wrdata: d[7:0], wren: 1'b1});
                    bus_cycle('0, '0, ram_req_t'{addr: a[10:0], wrdata: 8'h00, wren: 1'b0});
                    bus_cycle('0, '0, '0);
                    assert (chram_rddata == d[7:0])
                    else wrong_value($sformatf("chram_rddata[%0h]", a), d, int'(chram_rddata));
                end
                "R": begin
                    n = $fscanf(fd, "%h %h", a, e);
                    bus_cycle(io_req_t'{addr: a[3:0], wrdata: 8'h00, wren: 1'b0}, '0, '0);
                    assert (io_rddata == e[7:0])
                    else wrong_value($sformatf("io_rddata[%0h]", a), e, int'(io_rddata));
                end
                "P": begin
                    n = $fscanf(fd, "%h %h %h", a, d, e);
                    bus_cycle('0, '0, '0);
                    wait_pixel(a, d);
                    assert ({vga_r, vga_g, vga_b} == e[11:0])
                    else wrong_value("{vga_r,vga_g,vga_b}", e, int'({vga_r, vga_g, vga_b}));
                end
                "I": begin
                    n = $fscanf(fd, "%h %h", a, e);
                    bus_cycle('0, '0, '0);
                    wait_irq(a[0]);
                    bus_cycle(io_req_t'{addr: IRQSTAT, wrdata: 8'h00, wren: 1'b0}, '0, '0);
                    assert (io_rddata == e[7:0]) else wrong_value("IRQSTAT", e, int'(io_rddata));
                end
                default: stop_with($sformatf("unknown command %c in video_input.txt", cmd));
            endcase
        end
        $fclose(fd);

        if (vsync_checked) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_with("no full vga_vsync period was seen");
        end
    end

endmodule

/* video.sv */
`timescale 1ns/10ps

module video import video_pkg::*; #(
    parameter int H_ACTIVE     = 64,
    parameter int H_TOTAL      = 80,
    parameter int H_SYNC_START = 68,
    parameter int H_SYNC_END   = 72,
    parameter int V_ACTIVE     = 32,
    parameter int V_TOTAL      = 40,
    parameter int V_SYNC_START = 34,
    parameter int V_SYNC_END   = 36
) (
    input  logic       vclk,
    input  logic       reset,
    input  io_req_t    io,
    output logic [7:0] io_rddata,
    input  ram_req_t   tram,
    output logic [7:0] tram_rddata,
    input  ram_req_t   chram,
    output logic [7:0] chram_rddata,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b,
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic       irq
);

    raster_t     raster;
    vctrl_t      vctrl;
    logic [4:0]  palsel;
    logic [7:0]  pal_rddata;
    logic [3:0]  text_colidx;
    logic        text_active;     // Blank delayed through the pipeline
    logic [3:0]  pixel_colidx;
    logic [11:0] pal_rgb;
    logic [PIPE_DELAY-1:0] hsync_d;
    logic [PIPE_DELAY-1:0] vsync_d;

    video_timing #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
        .H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
        .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
        .V_SYNC_START(V_SYNC_START), .V_SYNC_END(V_SYNC_END)
    ) timing0 (.vclk(vclk), .reset(reset), .raster(raster));

    video_regs regs0 (
        .vclk(vclk), .reset(reset), .io(io), .io_rddata(io_rddata), .raster(raster),
        .vctrl(vctrl), .palsel(palsel), .palette_rddata(pal_rddata), .irq(irq)
    );

    text_fetch text0 (
        .vclk(vclk), .reset(reset), .raster(raster), .vctrl(vctrl),
        .tram(tram), .tram_rddata(tram_rddata), .chram(chram), .chram_rddata(chram_rddata),
        .colidx(text_colidx), .active(text_active)
    );

    palette pal0 (
        .vclk(vclk), .io(io), .palsel(palsel), .rddata(pal_rddata),
        .palidx(pixel_colidx), .rgb(pal_rgb)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Compositing and output
    ////////////////////////////////////////////////////////////////////////////
    assign pixel_colidx = (vctrl.text_enable && text_active) ? text_colidx : 4'd0;

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            hsync_d   <= '0;
            vsync_d   <= '0;
            vga_hsync <= 1'b0;
            vga_vsync <= 1'b0;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            hsync_d   <= {hsync_d[PIPE_DELAY-2:0], raster.hsync};  // Match colour path
            vsync_d   <= {vsync_d[PIPE_DELAY-2:0], raster.vsync};
            vga_hsync <= hsync_d[PIPE_DELAY-1];
            vga_vsync <= vsync_d[PIPE_DELAY-1];
            if (text_active)
                {vga_r, vga_g, vga_b} <= pal_rgb;
            else
                {vga_r, vga_g, vga_b} <= 12'h000;
        end
    end

endmodule

/* palette.sv */
`timescale 1ns/10ps

module palette import video_pkg::*; (
    input  logic        vclk,
    input  io_req_t     io,
    input  logic [4:0]  palsel,
    output logic [7:0]  rddata,
    input  logic [3:0]  palidx,
    output logic [11:0] rgb
);

    logic [11:0] pal_mem [16];     // {r, g, b}
    logic [3:0]  entry;
    logic        wr_en;

    assign entry = palsel[4:1];
    assign wr_en = io.wren && (io_reg_e'(io.addr) == VPALDATA);

    always_ff @(posedge vclk) begin
        if (wr_en) begin
            if (palsel[0])
                pal_mem[entry][11:8] <= io.wrdata[3:0];  // Red
            else
                pal_mem[entry][7:0]  <= io.wrdata;       // Green, blue
        end
    end

    // CPU readback of the selected byte
    assign rddata = palsel[0] ? {4'h0, pal_mem[entry][11:8]} : pal_mem[entry][7:0];

    // Pixel lookup
    assign rgb = pal_mem[palidx];

endmodule

/* text_fetch.sv */
`timescale 1ns/10ps

module text_fetch import video_pkg::*; (
    input  logic       vclk,
    input  logic       reset,
    input  raster_t    raster,
    input  vctrl_t     vctrl,
    input  ram_req_t   tram,
    output logic [7:0] tram_rddata,
    input  ram_req_t   chram,
    output logic [7:0] chram_rddata,
    output logic [3:0] colidx,
    output logic       active
);

    logic [7:0] tram_chr_mem [64];     // Character codes
    logic [7:0] tram_col_mem [64];     // Colour bytes
    logic [7:0] chram_mem    [2048];

    logic [5:0] cpu_cell;
    logic [5:0] vid_cell;
    logic [7:0] s1_chr;
    logic [7:0] s1_col;
    logic [2:0] s1_px;
    logic [2:0] s1_row;
    logic [7:0] s2_glyph;
    logic [7:0] s2_col;
    logic [2:0] s2_px;
    logic [PIPE_DELAY-1:0] blank_d;

    // Page, row, column
    assign cpu_cell = {tram.addr[6], tram.addr[5:1]};
    assign vid_cell = {vctrl.tram_page, raster.vpos[4:3], raster.hpos[5:3]};

    ////////////////////////////////////////////////////////////////////////////
    // CPU ports
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge vclk) begin
        if (tram.wren) begin
            if (tram.addr[0])
                tram_col_mem[cpu_cell] <= tram.wrdata;
            else
                tram_chr_mem[cpu_cell] <= tram.wrdata;
        end
        tram_rddata <= tram.addr[0] ? tram_col_mem[cpu_cell] : tram_chr_mem[cpu_cell];
    end

    always_ff @(posedge vclk) begin
        if (chram.wren)
            chram_mem[chram.addr] <= chram.wrdata;
        chram_rddata <= chram_mem[chram.addr];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Video pipeline
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge vclk) begin        // Stage 1, cell word
        s1_chr <= tram_chr_mem[vid_cell];
        s1_col <= tram_col_mem[vid_cell];
        s1_px  <= raster.hpos[2:0];
        s1_row <= raster.vpos[2:0];
    end

    always_ff @(posedge vclk) begin        // Stage 2, glyph row
        s2_glyph <= chram_mem[{s1_chr, s1_row}];
        s2_col   <= s1_col;
        s2_px    <= s1_px;
    end

    // Stage 3, bit 7 is leftmost
    always_ff @(posedge vclk)
        colidx <= s2_glyph[~s2_px] ? s2_col[7:4] : s2_col[3:0];

    always_ff @(posedge vclk or posedge reset) begin
        if (reset)
            blank_d <= '1;
        else
            blank_d <= {blank_d[PIPE_DELAY-2:0], raster.blank};
    end

    assign active = !blank_d[PIPE_DELAY-1];

endmodule

/* video_regs.sv */
`timescale 1ns/10ps

module video_regs import video_pkg::*; (
    input  logic       vclk,
    input  logic       reset,
    input  io_req_t    io,
    output logic [7:0] io_rddata,
    input  raster_t    raster,
    output vctrl_t     vctrl,
    output logic [4:0] palsel,
    input  logic [7:0] palette_rddata,
    output logic       irq
);

    io_reg_e    sel;
    logic [7:0] virqline;
    logic [1:0] irqmask;    // Bit 0 line, bit 1 vblank
    logic [1:0] irqstat;
    logic [1:0] irq_set;
    logic [1:0] irq_clr;
    logic       vblank_q;

    assign sel = io_reg_e'(io.addr);

    ////////////////////////////////////////////////////////////////////////////
    // Interrupt sources
    ////////////////////////////////////////////////////////////////////////////
    assign irq_set[0] = raster.line_start && ({2'b00, raster.vpos} == virqline);
    assign irq_set[1] = raster.vblank && !vblank_q;    // Rising edge of vblank
    assign irq_clr    = (io.wren && sel == IRQSTAT) ? io.wrdata[1:0] : 2'b00;
    assign irq        = |(irqstat & irqmask);

    ////////////////////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            vctrl    <= '0;
            palsel   <= '0;
            virqline <= '0;
            irqmask  <= '0;
            irqstat  <= '0;
            vblank_q <= 1'b0;
        end else begin
            vblank_q <= raster.vblank;

            // Write-one-to-clear, a new event wins
            irqstat <= (irqstat & ~irq_clr) | irq_set;

            if (io.wren) begin
                case (sel)
                    VCTRL: begin
                        vctrl.tram_page   <= io.wrdata[7];
                        vctrl.text_enable <= io.wrdata[0];
                    end
                    VPALSEL:  palsel   <= io.wrdata[4:0];
                    VIRQLINE: virqline <= io.wrdata;
                    IRQMASK:  irqmask  <= io.wrdata[1:0];
                    default: ;
                endcase
            end
        end
    end

    // Read mux
    always_comb begin
        case (sel)
            VCTRL:    io_rddata = {vctrl.tram_page, 6'b0, vctrl.text_enable};
            VPALSEL:  io_rddata = {3'b0, palsel};
            VPALDATA: io_rddata = palette_rddata;      // Through palette
            VLINE:    io_rddata = {2'b0, raster.vpos};
            VIRQLINE: io_rddata = virqline;
            IRQMASK:  io_rddata = {6'b0, irqmask};
            IRQSTAT:  io_rddata = {6'b0, irqstat};
            default:  io_rddata = 8'h00;
        endcase
    end

    // Masked sources never reach the CPU
    assert property (@(posedge vclk) disable iff (reset) (irqmask == 2'b00) |-> !irq);

endmodule

/* video_timing.sv */
`timescale 1ns/10ps

module video_timing import video_pkg::*; #(
    parameter int H_ACTIVE     = 64,
    parameter int H_TOTAL      = 80,
    parameter int H_SYNC_START = 68,
    parameter int H_SYNC_END   = 72,
    parameter int V_ACTIVE     = 32,
    parameter int V_TOTAL      = 40,
    parameter int V_SYNC_START = 34,
    parameter int V_SYNC_END   = 36
) (
    input  logic    vclk,
    input  logic    reset,
    output raster_t raster
);

    localparam logic [6:0] H_LAST   = 7'(H_TOTAL - 1);
    localparam logic [6:0] H_ACT    = 7'(H_ACTIVE);
    localparam logic [6:0] HS_START = 7'(H_SYNC_START);
    localparam logic [6:0] HS_END   = 7'(H_SYNC_END);
    localparam logic [5:0] V_LAST   = 6'(V_TOTAL - 1);
    localparam logic [5:0] V_ACT    = 6'(V_ACTIVE);
    localparam logic [5:0] VS_START = 6'(V_SYNC_START);
    localparam logic [5:0] VS_END   = 6'(V_SYNC_END);

    logic [6:0] hpos;
    logic [5:0] vpos;
    logic       hlast;

    assign hlast = (hpos == H_LAST);

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            hpos <= '0;
            vpos <= '0;
        end else begin
            hpos <= hlast ? 7'd0 : hpos + 7'd1;
            if (hlast)
                vpos <= (vpos == V_LAST) ? 6'd0 : vpos + 6'd1;  // Step line at wrap
        end
    end

    always_comb begin
        raster.hpos       = hpos;
        raster.vpos       = vpos;
        raster.hsync      = (hpos >= HS_START) && (hpos < HS_END);
        raster.vsync      = (vpos >= VS_START) && (vpos < VS_END);
        raster.vblank     = (vpos >= V_ACT);
        raster.blank      = (hpos >= H_ACT) || raster.vblank;
        raster.line_start = (hpos == 7'd0);
    end

    // Counters stay inside the frame
    assert property (@(posedge vclk) disable iff (reset) (hpos <= H_LAST) && (vpos <= V_LAST));

endmodule

/* video_pkg.sv */
package video_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // CPU side buses
    ////////////////////////////////////////////////////////////////////////////

    // I/O register access, one per cycle
    typedef struct packed {
        logic [3:0] addr;
        logic [7:0] wrdata;
        logic       wren;
    } io_req_t;

    // Text or char RAM access
    typedef struct packed {
        logic [10:0] addr;
        logic [7:0]  wrdata;
        logic        wren;
    } ram_req_t;

    ////////////////////////////////////////////////////////////////////////////
    // Raster and control
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] hpos;
        logic [5:0] vpos;
        logic       hsync;
        logic       vsync;
        logic       blank;       // Outside active area
        logic       vblank;
        logic       line_start;  // Single cycle at hpos 0
    } raster_t;

    // Decoded $E0
    typedef struct packed {
        logic text_enable;       // Bit 0
        logic tram_page;         // Bit 7
    } vctrl_t;

    typedef enum logic [3:0] {
        VCTRL    = 4'h0,
        VPALSEL  = 4'hA,
        VPALDATA = 4'hB,
        VLINE    = 4'hC,
        VIRQLINE = 4'hD,
        IRQMASK  = 4'hE,
        IRQSTAT  = 4'hF
    } io_reg_e;

    // Stages from raster position to colour index
    localparam int PIPE_DELAY = 3;

endpackage
